/* verilog.f */
source/silcPkg.sv
source/slopeCounter.sv
source/slopeMeasure.sv
source/silcController.sv
source/silcCollector.sv
dv/silcCollector_props.sv
dv/silcCollectorTb.sv

/* dv/silcCollectorTb.sv */
// testbench for silcCollector; sawtooth ADC with clean crossings only, lengths from a fixed-seed LFSR
`timescale 1ns/10ps

module silcCollectorTb
    import silcPkg::*;
();

    logic                     Clock;
    logic                     rstN;
    modeT                     mode;
    logic                     enable;
    logic [adcWidth-1:0]      adcSample;
    logic [slopeNumWidth-1:0] numSlopes;
    logic [timeWidth-1:0]     timeoutLimit;
    logic                     cpuReadComplete;
    logic [readingWidth-1:0]  silcReading;
    statusT                   status;
    logic                     silcValReady;

    // every driven sample by cycle number, read by the reference
    logic [adcWidth-1:0] sampleLog [0:16383];
    int                  cycleNum;

    // sawtooth generator state
    typedef enum {phHigh, phFall, phLow} wavePhaseT;
    wavePhaseT   phase;
    int          phaseLen;
    int          phasePos;
    logic        waveOn;
    logic [31:0] lfsrState;

    // expected values handed to the compare process
    logic                    checkReq;
    logic                    expValid;
    statusT                  expStatus;
    logic [readingWidth-1:0] expReading;
    string                   checkWhat;

    int checkCount;
    int errorCount;
    int testCount;
    int testsOk;
    int testStartErrors;
    int startIdx;
    logic [readingWidth-1:0] lastGoodReading;

    silcCollector u_silcCollector (.*);

    // 40 ns period
    always #20 Clock = ~Clock;

    always @(posedge Clock) cycleNum <= cycleNum + 1;

    // taps 32 22 2 1
    function automatic int randBits(input int n);
        int value;
        int i;
        value = 0;
        for (i = 0; i < n; i++) begin
            lfsrState = {lfsrState[30:0], lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
            value = (value << 1) | lfsrState[0];
        end
        return value;
    endfunction

    // new sawtooth phase with a random length
    task automatic startPhase(input wavePhaseT nextPhase);
        phase    = nextPhase;
        phasePos = 0;
        case (nextPhase)
            phHigh:  phaseLen = 3 + randBits(3);
            phFall:  phaseLen = 16 + randBits(5);
            default: phaseLen = 2 + randBits(3);
        endcase
    endtask

    // ADC driver, full scale plateau then linear fall to 0 then low plateau
    always @(posedge Clock) begin
        #2;
        if (!waveOn) begin
            adcSample = '1;
            phaseLen  = 0;
        end else begin
            if (phaseLen == 0) begin
                startPhase(phHigh);
            end else if (phasePos >= phaseLen) begin
                case (phase)
                    phHigh:  startPhase(phFall);
                    phFall:  startPhase(phLow);
                    default: startPhase(phHigh);
                endcase
            end
            case (phase)
                phHigh:  adcSample = '1;
                phFall:  adcSample = adcWidth'(4095 * (phaseLen - 1 - phasePos) / (phaseLen - 1));
                default: adcSample = '0;
            endcase
            phasePos = phasePos + 1;
        end
        if (cycleNum < 16384) begin
            sampleLog[cycleNum] = adcSample;
        end
    end

    // expected reading from the logged samples
    // each counted slope adds its end index minus its start index
    // only slopes whose upper crossing follows the start are counted
    function automatic logic [readingWidth-1:0] refReading(input int fromIdx, input int nSlopes,
                                                           input int toIdx);
        int sum;
        int found;
        int slopeStart;
        int i;
        bit inSlopeRef;
        sum        = 0;
        found      = 0;
        slopeStart = 0;
        inSlopeRef = 1'b0;
        for (i = fromIdx + 1; (i <= toIdx) && (found < nSlopes); i++) begin
            if (!inSlopeRef && (sampleLog[i] < upperThreshold)
                && (sampleLog[i-1] >= upperThreshold)) begin
                inSlopeRef = 1'b1;
                slopeStart = i;
            end else if (inSlopeRef && (sampleLog[i] < lowerThreshold)
                         && (sampleLog[i-1] >= lowerThreshold)) begin
                inSlopeRef = 1'b0;
                sum        = sum + (i - slopeStart);
                found      = found + 1;
            end
        end
        return readingWidth'(sum);
    endfunction

    // compare process, outputs are settled at the falling edge
    always @(negedge Clock) begin
        if (checkReq) begin
            checkCount = checkCount + 1;
            assert (silcValReady === expValid && status === expStatus
                    && silcReading === expReading)
            else begin
                errorCount = errorCount + 1;
                $display("CHECK FAILED at %0t: %s, got valid %0b status %0d reading %0d",
                         $time, checkWhat, silcValReady, status, silcReading);
                $display("    expected valid %0b status %0d reading %0d",
                         expValid, expStatus, expReading);
            end
            checkReq = 1'b0;
        end
    end

    task automatic nextCycle();
        @(posedge Clock);
        #2;
    endtask

    // hand one expectation to the compare process and wait for it
    task automatic checkOutputs(input logic validIn, input statusT statusIn,
                                input logic [readingWidth-1:0] readingIn, input string what);
        expValid   = validIn;
        expStatus  = statusIn;
        expReading = readingIn;
        checkWhat  = what;
        checkReq   = 1'b1;
        @(negedge Clock);
        #1;
    endtask

    // one-cycle read acknowledge from the CPU
    task automatic pulseRead();
        cpuReadComplete = 1'b1;
        nextCycle();
        cpuReadComplete = 1'b0;
    endtask

    // optionally checks the acquiring code on every cycle spent waiting
    task automatic waitForReady(input int maxCycles, input bit watchAcq, input string where);
        int waited;
        waited = 0;
        while (!silcValReady && (waited < maxCycles)) begin
            if (watchAcq) begin
                checkOutputs(1'b0, statusAcquiring, '0, "status while acquiring");
            end
            nextCycle();
            waited = waited + 1;
        end
        if (!silcValReady) begin
            $display("silcValReady stayed low for %0d cycles during %s", maxCycles, where);
            errorCount = errorCount + 1;
        end
    endtask

    // sample between the two thresholds with margin, so the lower crossing is still ahead
    task automatic waitForMidDescent(input int maxCycles);
        int waited;
        waited = 0;
        @(negedge Clock);
        while (!((adcSample < upperThreshold) && (adcSample >= lowerThreshold + 600))
               && (waited < maxCycles)) begin
            @(negedge Clock);
            waited = waited + 1;
        end
        if (waited >= maxCycles) begin
            $display("ADC never reached the middle of a descent within %0d cycles", maxCycles);
            errorCount = errorCount + 1;
        end
    endtask

    task automatic finishTest(input string name);
        testCount = testCount + 1;
        if (errorCount == testStartErrors) begin
            testsOk = testsOk + 1;
            $display("test %0d %s ok", testCount, name);
        end else begin
            $display("test %0d %s had %0d errors", testCount, name, errorCount - testStartErrors);
        end
        testStartErrors = errorCount;
    endtask

    initial begin
        Clock           = 1'b0;
        rstN            = 1'b0;
        mode            = modeStop;
        enable          = 1'b1;
        adcSample       = '1;
        numSlopes       = '0;
        timeoutLimit    = '0;
        cpuReadComplete = 1'b0;
        waveOn          = 1'b0;
        phase           = phHigh;
        phaseLen        = 0;
        phasePos        = 0;
        lfsrState       = 32'h2764;
        cycleNum        = 0;
        checkReq        = 1'b0;
        expValid        = 1'b0;
        expStatus       = statusIdle;
        expReading      = '0;
        checkWhat       = "";
        checkCount      = 0;
        errorCount      = 0;
        testCount       = 0;
        testsOk         = 0;
        testStartErrors = 0;
        startIdx        = 0;
        lastGoodReading = '0;
        // reset over three rising edges
        repeat (3) @(posedge Clock);
        #2;
        rstN = 1'b1;
        checkOutputs(1'b0, statusIdle, '0, "idle after reset");
        waveOn = 1'b1;

        // slow measurement over three slopes
        nextCycle();
        numSlopes    = 6'd3;
        timeoutLimit = 12'd2000;
        mode         = modeSlow;
        startIdx     = cycleNum;
        nextCycle();
        waitForReady(1000, 1'b1, "slow measurement");
        checkOutputs(1'b1, statusReady, refReading(startIdx, 3, cycleNum - 1), "slow reading");
        finishTest("slow measurement");

        // start inside a descent, that slope must not count
        nextCycle();
        mode = modeStop;
        nextCycle();
        checkOutputs(1'b0, statusIdle, '0, "stop before partial slope");
        waitForMidDescent(200);
        nextCycle();
        mode      = modeSlow;
        numSlopes = 6'd2;
        startIdx  = cycleNum;
        nextCycle();
        waitForReady(1000, 1'b1, "partial slope measurement");
        lastGoodReading = refReading(startIdx, 2, cycleNum - 1);
        checkOutputs(1'b1, statusReady, lastGoodReading, "partial slope skipped");
        finishTest("partial first slope");

        // fast shows the stored reading with a flat input
        nextCycle();
        mode = modeStop;
        nextCycle();
        checkOutputs(1'b0, statusIdle, '0, "stop before fast");
        waveOn = 1'b0;
        nextCycle();
        mode = modeFast;
        nextCycle();
        checkOutputs(1'b1, statusReady, lastGoodReading, "fast shows stored reading");
        nextCycle();
        pulseRead();
        checkOutputs(1'b1, statusReady, lastGoodReading, "fast after read");
        finishTest("fast mode");

        // read acknowledge with slow selected starts a new measurement
        waveOn = 1'b1;
        nextCycle();
        mode      = modeSlow;
        numSlopes = 6'd2;
        startIdx  = cycleNum;
        pulseRead();
        waitForReady(1000, 1'b1, "repeated measurement");
        lastGoodReading = refReading(startIdx, 2, cycleNum - 1);
        checkOutputs(1'b1, statusReady, lastGoodReading, "repeated reading");
        finishTest("repeated slow measurement");

        // limit far below one slope
        nextCycle();
        timeoutLimit = 12'd5;
        pulseRead();
        waitForReady(100, 1'b1, "timeout measurement");
        checkOutputs(1'b1, statusTimedOut, lastGoodReading, "timeout keeps reading");
        nextCycle();
        pulseRead();
        checkOutputs(1'b1, statusTimedOut, lastGoodReading, "timeout holds after read");
        finishTest("timeout");

        // stop, mode 3 and enable low all clear the outputs
        nextCycle();
        mode = modeStop;
        nextCycle();
        checkOutputs(1'b0, statusIdle, '0, "stop clears timeout");
        nextCycle();
        nextCycle();
        checkOutputs(1'b0, statusIdle, '0, "stop holds");
        nextCycle();
        mode = modeFast;
        nextCycle();
        checkOutputs(1'b1, statusReady, lastGoodReading, "fast after stop");
        nextCycle();
        mode = modeReserved;
        nextCycle();
        checkOutputs(1'b0, statusIdle, '0, "mode 3 acts as stop");
        nextCycle();
        mode = modeFast;
        nextCycle();
        checkOutputs(1'b1, statusReady, lastGoodReading, "fast after mode 3");
        nextCycle();
        enable = 1'b0;
        nextCycle();
        checkOutputs(1'b0, statusIdle, '0, "enable low clears");
        nextCycle();
        checkOutputs(1'b0, statusIdle, '0, "held while disabled");
        nextCycle();
        enable = 1'b1;
        nextCycle();
        checkOutputs(1'b1, statusReady, lastGoodReading, "fast after enable");
        finishTest("stop and disable");

        $display("tests %0d, ok %0d, checks %0d, errors %0d",
                 testCount, testsOk, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* dv/silcCollector_props.sv */
// output assertions bound into silcCollector; cycles with rstN low are not checked
`timescale 1ns/10ps

module silcCollectorProps
    import silcPkg::*;
(
    input logic                    Clock,
    input logic                    rstN,
    input logic                    enable,
    input logic [readingWidth-1:0] silcReading,
    input statusT                  status,
    input logic                    silcValReady
);

    // valid flag follows the two result codes
    validFollowsStatus: assert property (@(posedge Clock) disable iff (!rstN)
        silcValReady == ((status == statusReady) || (status == statusTimedOut)))
    else $error("silcValReady disagrees with status %0d", status);

    // no stale reading while nothing is valid
    readingZeroWhenInvalid: assert property (@(posedge Clock) disable iff (!rstN)
        !silcValReady |-> (silcReading == '0))
    else $error("silcReading nonzero while silcValReady is low");

    // enable low clears everything on the next cycle
    disableClears: assert property (@(posedge Clock) disable iff (!rstN)
        !enable |=> (!silcValReady && (silcReading == '0) && (status == statusIdle)))
    else $error("outputs not cleared one cycle after enable went low");

endmodule

bind silcCollector silcCollectorProps u_silcCollectorProps (
    .Clock        (Clock),
    .rstN         (rstN),
    .enable       (enable),
    .silcReading  (silcReading),
    .status       (status),
    .silcValReady (silcValReady)
);

/* source/silcCollector.sv */
// top level; outputs are combinational from controller state, mode 3 acts like stop
`timescale 1ns/10ps

module silcCollector
    import silcPkg::*;
(
    input  logic                     Clock,
    input  logic                     rstN,
    input  modeT                     mode,
    input  logic                     enable,
    input  logic [adcWidth-1:0]      adcSample,
    input  logic [slopeNumWidth-1:0] numSlopes,
    input  logic [timeWidth-1:0]     timeoutLimit,
    input  logic                     cpuReadComplete,
    output logic [readingWidth-1:0]  silcReading,
    output statusT                   status,
    output logic                     silcValReady
);

    // level, high for the whole measurement
    logic startMeasure;

    // measurement result back to the controller
    logic                    measureDone;
    logic                    measureTimeout;
    logic [readingWidth-1:0] cycleCount;

    // mode machine and CPU side
    silcController u_silcController (
        .Clock           (Clock),
        .rstN            (rstN),
        .mode            (mode),
        .enable          (enable),
        .cpuReadComplete (cpuReadComplete),
        .measureDone     (measureDone),
        .measureTimeout  (measureTimeout),
        .cycleCount      (cycleCount),
        .startMeasure    (startMeasure),
        .silcReading     (silcReading),
        .status          (status),
        .silcValReady    (silcValReady)
    );

    // slope measurement with its counters
    slopeMeasure u_slopeMeasure (
        .Clock          (Clock),
        .rstN           (rstN),
        .startMeasure   (startMeasure),
        .adcSample      (adcSample),
        .numSlopes      (numSlopes),
        .timeoutLimit   (timeoutLimit),
        .measureDone    (measureDone),
        .measureTimeout (measureTimeout),
        .cycleCount     (cycleCount)
    );

endmodule

/* source/silcController.sv */
// mode FSM; timed-out state holds until stop or enable low, stored reading survives enable low
`timescale 1ns/10ps

module silcController
    import silcPkg::*;
(
    input  logic                    Clock,
    input  logic                    rstN,
    input  modeT                    mode,
    input  logic                    enable,
    input  logic                    cpuReadComplete,
    input  logic                    measureDone,
    input  logic                    measureTimeout,
    input  logic [readingWidth-1:0] cycleCount,
    output logic                    startMeasure,
    output logic [readingWidth-1:0] silcReading,
    output statusT                  status,
    output logic                    silcValReady
);

    typedef enum logic [1:0] {
        stIdle,
        stReady,
        stAcquiring,
        stTimedOut
    } ctrlStateT;

    ctrlStateT state;
    ctrlStateT nextState;

    // last good reading, 0 until the first successful measurement
    logic [readingWidth-1:0] storedReading;

    // stop, mode 3 or enable low all force idle
    logic forceIdle;

    // measurement finished cleanly this cycle
    logic captureReading;

    assign forceIdle = !enable || (mode == modeStop) || (mode == modeReserved);

    assign captureReading = (state == stAcquiring) && measureDone && !measureTimeout
                            && !forceIdle;

    // next state, ignoring the forced idle which the register applies
    always_comb begin
        nextState = state;
        case (state)
            stIdle: begin
                // fast skips measuring and shows the stored reading
                if (mode == modeFast) begin
                    nextState = stReady;
                end else if (mode == modeSlow) begin
                    nextState = stAcquiring;
                end
            end
            stReady: begin
                // wait for the CPU to take the value
                if (cpuReadComplete) begin
                    if (mode == modeSlow) begin
                        nextState = stAcquiring;
                    end else if (mode == modeFast) begin
                        nextState = stReady;
                    end else begin
                        nextState = stIdle;
                    end
                end
            end
            stAcquiring: begin
                if (measureDone) begin
                    nextState = measureTimeout ? stTimedOut : stReady;
                end
            end
            stTimedOut: begin
                // sticky, only stop or disable gets out
                nextState = stTimedOut;
            end
            default: begin
                nextState = stIdle;
            end
        endcase
    end

    always_ff @(posedge Clock) begin
        if (!rstN || forceIdle) begin
            state <= stIdle;
        end else begin
            state <= nextState;
        end
    end

    // reading only moves on a clean finish, a timeout keeps the old one
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            storedReading <= '0;
        end else if (captureReading) begin
            storedReading <= cycleCount;
        end
    end

    // CPU side outputs follow the state
    always_comb begin
        startMeasure = 1'b0;
        silcReading  = '0;
        status       = statusIdle;
        silcValReady = 1'b0;
        case (state)
            stReady: begin
                silcReading  = storedReading;
                status       = statusReady;
                silcValReady = 1'b1;
            end
            stAcquiring: begin
                startMeasure = 1'b1;
                status       = statusAcquiring;
            end
            stTimedOut: begin
                // previous good reading with the timeout code
                silcReading  = storedReading;
                status       = statusTimedOut;
                silcValReady = 1'b1;
            end
            default: begin
                status = statusIdle;
            end
        endcase
    end

endmodule

/* source/slopeMeasure.sv */
// measurement FSM; slope target and time limit are latched at start, dropping startMeasure aborts
`timescale 1ns/10ps

module slopeMeasure
    import silcPkg::*;
(
    input  logic                     Clock,
    input  logic                     rstN,
    input  logic                     startMeasure,
    input  logic [adcWidth-1:0]      adcSample,
    input  logic [slopeNumWidth-1:0] numSlopes,
    input  logic [timeWidth-1:0]     timeoutLimit,
    output logic                     measureDone,
    output logic                     measureTimeout,
    output logic [readingWidth-1:0]  cycleCount
);

    typedef enum logic [1:0] {
        msIdle,
        msAcquiring,
        msComplete,
        msTimedOut
    } measStateT;

    measStateT state;

    // configuration held for the whole measurement
    logic [slopeNumWidth-1:0] slopeTarget;
    logic [timeWidth-1:0]     timeLimit;

    // counter control
    logic countActive;
    logic holdData;

    // counter results
    logic [readingWidth-1:0]  elapsedCycles;
    logic [slopeNumWidth-1:0] slopesSeen;
    logic [timeWidth-1:0]     elapsedTime;

    always_ff @(posedge Clock) begin
        if (!rstN || !startMeasure) begin
            // abort or no request
            state <= msIdle;
        end else begin
            case (state)
                msIdle: begin
                    state <= msAcquiring;
                end
                msAcquiring: begin
                    // timeout wins over completion in the same cycle
                    if (elapsedTime >= timeLimit) begin
                        state <= msTimedOut;
                    end else if (slopesSeen >= slopeTarget) begin
                        state <= msComplete;
                    end
                end
                default: begin
                    // complete and timed out hold until startMeasure falls
                    state <= state;
                end
            endcase
        end
    end

    // latch CPU settings on the first start cycle
    always_ff @(posedge Clock) begin
        if ((state == msIdle) && startMeasure) begin
            slopeTarget <= numSlopes;
            timeLimit   <= timeoutLimit;
        end
    end

    // counting only in acquiring, results kept through complete
    assign countActive = (state == msAcquiring);
    assign holdData    = (state == msAcquiring) || (state == msComplete);

    assign measureDone    = (state == msComplete) || (state == msTimedOut);
    assign measureTimeout = (state == msTimedOut);

    // count is only meaningful after a clean finish
    assign cycleCount = (state == msComplete) ? elapsedCycles : '0;

    slopeCounter u_slopeCounter (
        .Clock         (Clock),
        .rstN          (rstN),
        .countActive   (countActive),
        .holdData      (holdData),
        .adcSample     (adcSample),
        .elapsedCycles (elapsedCycles),
        .slopesSeen    (slopesSeen),
        .elapsedTime   (elapsedTime)
    );

endmodule

/* source/slopeCounter.sv */
// slope counter; needs clean monotonic crossings, counters wrap silently past their widths
`timescale 1ns/10ps

module slopeCounter
    import silcPkg::*;
(
    input  logic                     Clock,
    input  logic                     rstN,
    input  logic                     countActive,
    input  logic                     holdData,
    input  logic [adcWidth-1:0]      adcSample,
    output logic [readingWidth-1:0]  elapsedCycles,
    output logic [slopeNumWidth-1:0] slopesSeen,
    output logic [timeWidth-1:0]     elapsedTime
);

    // two sample stages, current and previous
    logic [adcWidth-1:0] adcReg;
    logic [adcWidth-1:0] adcPrev;

    // crossing strobes from the registered samples
    logic upperCross;
    logic lowerCross;

    // set between a start crossing and its end crossing
    logic inSlope;

    // sample pipeline runs freely
    always_ff @(posedge Clock) begin
        adcReg  <= adcSample;
        adcPrev <= adcReg;
    end

    // falling through 75 %
    assign upperCross = (adcReg < upperThreshold) && (adcPrev >= upperThreshold);

    // falling through 25 %
    assign lowerCross = (adcReg < lowerThreshold) && (adcPrev >= lowerThreshold);

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            inSlope       <= 1'b0;
            elapsedCycles <= '0;
            slopesSeen    <= '0;
            elapsedTime   <= '0;
        end else if (countActive) begin
            // time since the measurement began, for the timeout
            elapsedTime <= elapsedTime + 1'b1;
            if (upperCross) begin
                inSlope <= 1'b1;
            end else if (lowerCross && inSlope) begin
                // only a slope whose start was seen counts
                // so a descent already under way at start is skipped
                inSlope    <= 1'b0;
                slopesSeen <= slopesSeen + 1'b1;
            end
            // the end cycle still counts, giving end minus start cycles per slope
            if (inSlope) begin
                elapsedCycles <= elapsedCycles + 1'b1;
            end
        end else if (!holdData) begin
            // nothing to keep, start over
            inSlope       <= 1'b0;
            elapsedCycles <= '0;
            slopesSeen    <= '0;
            elapsedTime   <= '0;
        end
    end

endmodule

/* source/silcPkg.sv */
// shared widths, ADC thresholds and encodings; thresholds assume a 12-bit unipolar ADC
package silcPkg;

    // ADC sample width
    localparam int adcWidth = 12;

    // cycle count and stored reading width
    localparam int readingWidth = 16;

    // number of slopes the CPU can ask for, up to 63
    localparam int slopeNumWidth = 6;

    // timeout threshold and elapsed time, so at most 4095 cycles per measurement
    localparam int timeWidth = 12;

    // slope starts when the sample falls below 75 % of full scale
    localparam logic [adcWidth-1:0] upperThreshold = 12'd3071;

    // slope ends when the sample falls below 25 % of full scale
    localparam logic [adcWidth-1:0] lowerThreshold = 12'd1023;

    // operating mode chosen by the CPU
    // value 3 is not a real mode and behaves like stop
    typedef enum logic [1:0] {
        modeStop     = 2'd0,
        modeFast     = 2'd1,
        modeSlow     = 2'd2,
        modeReserved = 2'd3
    } modeT;

    // status code seen by the CPU
    // 1 means a good reading, 7 means the last measurement timed out
    typedef enum logic [2:0] {
        statusIdle      = 3'd0,
        statusReady     = 3'd1,
        statusAcquiring = 3'd3,
        statusTimedOut  = 3'd7
    } statusT;

endpackage
